/* Bender.yml */
package:
  name: aluCore

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/aluPkg.sv
      - rtl/adderSlice.sv
      - rtl/addSubUnit.sv
      - rtl/aluDatapath.sv
      - rtl/aluHandshake.sv
      - rtl/aluCore.sv
  - target: simulation
    include_dirs:
      - include
      - tb
    files:
      - tb/aluCoreTb.sv

/* aluCore.f */
+incdir+include
+incdir+tb
rtl/aluPkg.sv
rtl/adderSlice.sv
rtl/addSubUnit.sv
rtl/aluDatapath.sv
rtl/aluHandshake.sv
rtl/aluCore.sv
tb/aluCoreTb.sv

/* include/alu_settings.svh */
// ALU settings: operand width and ripple slice width for the adder
`ifndef ALU_SETTINGS_SVH
`define ALU_SETTINGS_SVH

// operand and result width
`define ALU_WIDTH 32

// bits per ripple carry slice, must divide ALU_WIDTH
`define SLICE_WIDTH 4

`endif

/* rtl/addSubUnit.sv */
// Add/subtract unit: chained ripple slices with carry out and signed overflow
`timescale 1ns/1ps
`include "alu_settings.svh"

module addSubUnit
(
    input  logic                  clk,
    input  logic [`ALU_WIDTH-1:0] a,
    input  logic [`ALU_WIDTH-1:0] b,
    input  logic                  subtract,
    output logic [`ALU_WIDTH-1:0] sum,
    output logic                  carryout,
    output logic                  overflow
);

    localparam int numSlices = `ALU_WIDTH / `SLICE_WIDTH;

    logic [`ALU_WIDTH-1:0] operandB;  // b, or its inverse when subtracting
    logic [numSlices:0]    carry;     // carry between slices
    logic [numSlices-1:0]  sliceTop;  // carry into each slice's top bit

    generate
        if (`ALU_WIDTH % `SLICE_WIDTH != 0)
        begin : gBadSliceWidth
            $error("slice width must divide the ALU width");
        end
    endgenerate

    // two's complement subtract: invert b and carry in a one
    assign operandB = b ^ {`ALU_WIDTH{subtract}};
    assign carry[0] = subtract;

    genvar s;
    generate
        for (s = 0; s < numSlices; s++)
        begin : gSlice
            adderSlice u_slice
            (
                .a        (a[s*`SLICE_WIDTH +: `SLICE_WIDTH]),
                .b        (operandB[s*`SLICE_WIDTH +: `SLICE_WIDTH]),
                .carryin  (carry[s]),
                .sum      (sum[s*`SLICE_WIDTH +: `SLICE_WIDTH]),
                .carryout (carry[s+1]),
                .carryTop (sliceTop[s])
            );
        end
    endgenerate

    assign carryout = carry[numSlices];
    assign overflow = sliceTop[numSlices-1] ^ carry[numSlices];  // carry in vs out of msb

    // ripple chain must agree with wide arithmetic
    aSumMatch: assert property (@(posedge clk)
        !$isunknown({a, b, subtract}) |->
            ({carryout, sum} == ({1'b0, a} + {1'b0, operandB}
                                 + {{`ALU_WIDTH{1'b0}}, subtract})))
        else $error("adder chain disagrees with wide sum");

    // overflow only when like-signed operands give a differently signed sum
    aOverflowSign: assert property (@(posedge clk)
        !$isunknown({a, b, subtract}) |->
            (overflow == ((a[`ALU_WIDTH-1] == operandB[`ALU_WIDTH-1])
                          && (sum[`ALU_WIDTH-1] != a[`ALU_WIDTH-1]))))
        else $error("overflow flag disagrees with operand signs");

endmodule

/* rtl/adderSlice.sv */
// Adder slice: ripple carry chain of one-bit full adders
`timescale 1ns/1ps
`include "alu_settings.svh"

module adderSlice
(
    input  logic [`SLICE_WIDTH-1:0] a,
    input  logic [`SLICE_WIDTH-1:0] b,
    input  logic                    carryin,
    output logic [`SLICE_WIDTH-1:0] sum,
    output logic                    carryout,
    output logic                    carryTop
);

    // carry[i] is the carry into bit i
    logic [`SLICE_WIDTH:0] carry;

    assign carry[0] = carryin;

    genvar i;
    generate
        for (i = 0; i < `SLICE_WIDTH; i++)
        begin : gFullAdder
            // sum is high for one or three high inputs
            assign sum[i] = a[i] ^ b[i] ^ carry[i];

            // majority of the three inputs
            assign carry[i+1] = (a[i] & b[i])
                              | (a[i] & carry[i])
                              | (b[i] & carry[i]);
        end
    endgenerate

    assign carryout = carry[`SLICE_WIDTH];
    assign carryTop = carry[`SLICE_WIDTH-1];  // needed for overflow in the top slice

endmodule

/* rtl/aluCore.sv */
// ALU core: handshake controller driving the combinational datapath
`timescale 1ns/1ps

module aluCore
(
    input  logic              clk,
    input  logic              reset,
    input  logic              req,
    output logic              ack,
    input  aluPkg::aluRequest request,
    output aluPkg::aluResult  result
);

    aluPkg::aluRequest issued;    // registered request into the datapath
    aluPkg::aluResult  computed;  // combinational datapath output

    aluHandshake u_handshake
    (
        .clk      (clk),
        .reset    (reset),
        .req      (req),
        .ack      (ack),
        .request  (request),
        .issued   (issued),
        .computed (computed),
        .result   (result)
    );

    aluDatapath u_datapath
    (
        .clk     (clk),
        .request (issued),
        .result  (computed)
    );

endmodule

/* rtl/aluDatapath.sv */
// ALU datapath: adder beside bitwise logic, with result and flag selection
`timescale 1ns/1ps
`include "alu_settings.svh"

module aluDatapath
(
    input  logic              clk,
    input  aluPkg::aluRequest request,
    output aluPkg::aluResult  result
);

    logic                  subtract;
    logic [`ALU_WIDTH-1:0] sum;
    logic                  adderCarry;
    logic                  adderOverflow;
    logic                  lessThan;
    logic [`ALU_WIDTH-1:0] value;
    logic                  carryout;
    logic                  overflow;

    // slt is a subtraction as far as the adder is concerned
    assign subtract = (request.op == aluPkg::OP_SUB)
                   || (request.op == aluPkg::OP_SLT);

    addSubUnit u_addSub
    (
        .clk      (clk),
        .a        (request.a),
        .b        (request.b),
        .subtract (subtract),
        .sum      (sum),
        .carryout (adderCarry),
        .overflow (adderOverflow)
    );

    // sign of a - b, corrected when the subtraction overflowed
    assign lessThan = sum[`ALU_WIDTH-1] ^ adderOverflow;

    always_comb
    begin
        value    = '0;
        carryout = 1'b0;   // logic ops leave both flags low
        overflow = 1'b0;
        case (request.op)
            aluPkg::OP_ADD,
            aluPkg::OP_SUB:
            begin
                value    = sum;
                carryout = adderCarry;
                overflow = adderOverflow;
            end
            aluPkg::OP_SLT:
            begin
                value    = {{(`ALU_WIDTH-1){1'b0}}, lessThan};
                carryout = adderCarry;      // flags of the subtraction
                overflow = adderOverflow;
            end
            aluPkg::OP_AND:  value = request.a & request.b;
            aluPkg::OP_OR:   value = request.a | request.b;
            aluPkg::OP_XOR:  value = request.a ^ request.b;
            aluPkg::OP_NAND: value = ~(request.a & request.b);
            aluPkg::OP_NOR:  value = ~(request.a | request.b);
            default:         value = '0;
        endcase
    end

    // zero flag covers every opcode
    assign result = '{
        value:    value,
        carryout: carryout,
        overflow: overflow,
        zero:     (value == '0)
    };

endmodule

/* rtl/aluHandshake.sv */
// ALU handshake controller: four-phase req/ack with latched request and held result
`timescale 1ns/1ps

module aluHandshake
(
    input  logic              clk,
    input  logic              reset,
    input  logic              req,
    output logic              ack,
    input  aluPkg::aluRequest request,
    output aluPkg::aluRequest issued,
    input  aluPkg::aluResult  computed,
    output aluPkg::aluResult  result
);

    aluPkg::ctrlState state;
    aluPkg::ctrlState nextState;

    always_comb
    begin
        nextState = state;
        case (state)
            aluPkg::IDLE:
            begin
                if (req)
                    nextState = aluPkg::EXEC;
            end
            aluPkg::EXEC:    nextState = aluPkg::ACK;      // datapath has settled
            aluPkg::ACK:
            begin
                if (!req)
                    nextState = aluPkg::RELEASE;         // requester is done
            end
            aluPkg::RELEASE: nextState = aluPkg::IDLE;
            default:         nextState = aluPkg::IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= aluPkg::IDLE;
        else
            state <= nextState;
    end

    // ack follows the ACK state one edge later, and drops on the edge that sees req low
    always_ff @(posedge clk)
    begin
        if (reset)
            ack <= 1'b0;
        else
            ack <= (state == aluPkg::ACK) && req;
    end

    // operands are captured once per handshake
    always_ff @(posedge clk)
    begin
        if (state == aluPkg::IDLE && req)
            issued <= request;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            result <= '0;
        else if (state == aluPkg::EXEC)
            result <= computed;   // held until the next request
    end

    // ack only rises for a req sampled in IDLE three edges back and still high
    aAckNeedsReq: assert property (@(posedge clk) disable iff (reset)
        $rose(ack) |-> ($past(req) && $past(state == aluPkg::IDLE && req, 3)))
        else $error("ack rose without req");

    aResultHeld: assert property (@(posedge clk) disable iff (reset)
        (ack && $past(ack)) |-> $stable(result))
        else $error("result changed while ack was high");

    // back-pressure keeps the controller parked in ACK
    aHoldAck: assert property (@(posedge clk) disable iff (reset)
        (ack && req) |=> (ack && state == aluPkg::ACK))
        else $error("controller left ACK while req was high");

endmodule

/* rtl/aluPkg.sv */
// ALU package: opcodes, controller states, and the request and result structs
`include "alu_settings.svh"

package aluPkg;

    // operations decoded by the datapath
    typedef enum logic [2:0]
    {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_AND  = 3'd2,
        OP_OR   = 3'd3,
        OP_XOR  = 3'd4,
        OP_NAND = 3'd5,
        OP_NOR  = 3'd6,
        OP_SLT  = 3'd7   // signed set less than
    } aluOp;

    // one operation as seen by the datapath
    typedef struct packed
    {
        aluOp                  op;
        logic [`ALU_WIDTH-1:0] a;
        logic [`ALU_WIDTH-1:0] b;
    } aluRequest;

    // value plus flags
    typedef struct packed
    {
        logic [`ALU_WIDTH-1:0] value;
        logic                  carryout;  // adder carry, 1 means no borrow on subtract
        logic                  overflow;  // signed overflow
        logic                  zero;      // value is all zeros
    } aluResult;

    // four-phase controller states
    typedef enum logic [1:0]
    {
        IDLE    = 2'd0,  // waiting for req
        EXEC    = 2'd1,  // request latched, datapath settling
        ACK     = 2'd2,  // result held, ack driven
        RELEASE = 2'd3   // req seen low, one cycle gap
    } ctrlState;

endpackage

/* tb/aluVectors.svh */
// ALU test vectors: directed requests paired with their expected results
`ifndef ALU_VECTORS_SVH
`define ALU_VECTORS_SVH

// one directed transaction
typedef struct packed
{
    aluPkg::aluRequest request;
    aluPkg::aluResult  expected;   // value, carryout, overflow, zero
} vectorEntry;

localparam int numVectors = 25;

localparam vectorEntry vectors [numVectors] = '{
    // add: plain, carry out of the top bit, overflow, mixed signs
    '{'{aluPkg::OP_ADD, 32'h0000_0001, 32'h0000_0002}, '{32'h0000_0003, 1'b0, 1'b0, 1'b0}},
    '{'{aluPkg::OP_ADD, 32'hFFFF_FFFF, 32'h0000_0001}, '{32'h0000_0000, 1'b1, 1'b0, 1'b1}},
    '{'{aluPkg::OP_ADD, 32'h7FFF_FFFF, 32'h0000_0001}, '{32'h8000_0000, 1'b0, 1'b1, 1'b0}},
    '{'{aluPkg::OP_ADD, 32'h8000_0000, 32'h8000_0000}, '{32'h0000_0000, 1'b1, 1'b1, 1'b1}},
    '{'{aluPkg::OP_ADD, 32'h7FFF_FFFF, 32'hFFFF_FFFF}, '{32'h7FFF_FFFE, 1'b1, 1'b0, 1'b0}},
    '{'{aluPkg::OP_ADD, 32'h0000_0005, 32'hFFFF_FFFB}, '{32'h0000_0000, 1'b1, 1'b0, 1'b1}},
    // sub: zero minus zero, no borrow, borrow, most negative minus one
    '{'{aluPkg::OP_SUB, 32'h0000_0000, 32'h0000_0000}, '{32'h0000_0000, 1'b1, 1'b0, 1'b1}},
    '{'{aluPkg::OP_SUB, 32'h0000_0005, 32'h0000_0003}, '{32'h0000_0002, 1'b1, 1'b0, 1'b0}},
    '{'{aluPkg::OP_SUB, 32'h0000_0003, 32'h0000_0005}, '{32'hFFFF_FFFE, 1'b0, 1'b0, 1'b0}},
    '{'{aluPkg::OP_SUB, 32'h8000_0000, 32'h0000_0001}, '{32'h7FFF_FFFF, 1'b1, 1'b1, 1'b0}},
    // signed compares, the last two overflow inside the subtraction
    '{'{aluPkg::OP_SLT, 32'hFFFF_FFFF, 32'h0000_0001}, '{32'h0000_0001, 1'b1, 1'b0, 1'b0}},
    '{'{aluPkg::OP_SLT, 32'h0000_0001, 32'hFFFF_FFFF}, '{32'h0000_0000, 1'b0, 1'b0, 1'b1}},
    '{'{aluPkg::OP_SLT, 32'h1234_5678, 32'h1234_5678}, '{32'h0000_0000, 1'b1, 1'b0, 1'b1}},
    '{'{aluPkg::OP_SLT, 32'h8000_0000, 32'h0000_0001}, '{32'h0000_0001, 1'b1, 1'b1, 1'b0}},
    '{'{aluPkg::OP_SLT, 32'h7FFF_FFFF, 32'h8000_0000}, '{32'h0000_0000, 1'b0, 1'b1, 1'b1}},
    // bitwise ops, flags stay low apart from zero
    '{'{aluPkg::OP_AND, 32'hF0F0_F0F0, 32'hFF00_FF00}, '{32'hF000_F000, 1'b0, 1'b0, 1'b0}},
    '{'{aluPkg::OP_AND, 32'hAAAA_AAAA, 32'h5555_5555}, '{32'h0000_0000, 1'b0, 1'b0, 1'b1}},
    '{'{aluPkg::OP_OR,  32'h1234_0000, 32'h0000_5678}, '{32'h1234_5678, 1'b0, 1'b0, 1'b0}},
    '{'{aluPkg::OP_OR,  32'h0000_0000, 32'h0000_0000}, '{32'h0000_0000, 1'b0, 1'b0, 1'b1}},
    '{'{aluPkg::OP_XOR, 32'hDEAD_BEEF, 32'hDEAD_BEEF}, '{32'h0000_0000, 1'b0, 1'b0, 1'b1}},
    '{'{aluPkg::OP_XOR, 32'hFFFF_0000, 32'h0F0F_0F0F}, '{32'hF0F0_0F0F, 1'b0, 1'b0, 1'b0}},
    '{'{aluPkg::OP_NAND, 32'hFFFF_FFFF, 32'hFFFF_FFFF}, '{32'h0000_0000, 1'b0, 1'b0, 1'b1}},
    '{'{aluPkg::OP_NAND, 32'h0F0F_0F0F, 32'h00FF_00FF}, '{32'hFFF0_FFF0, 1'b0, 1'b0, 1'b0}},
    '{'{aluPkg::OP_NOR, 32'h0000_0000, 32'h0000_0000}, '{32'hFFFF_FFFF, 1'b0, 1'b0, 1'b0}},
    '{'{aluPkg::OP_NOR, 32'hF000_0000, 32'h0000_000F}, '{32'h0FFF_FFF0, 1'b0, 1'b0, 1'b0}}
};

`endif

/* tb/aluCoreTb.sv */
// ALU core testbench: four-phase handshake driver with directed and random checks
`timescale 1ns/1ps
`include "alu_settings.svh"

module aluCoreTb;

    logic              clk;
    logic              reset;
    logic              req;
    logic              ack;
    aluPkg::aluRequest request;
    aluPkg::aluResult  result;

    `include "aluVectors.svh"

    localparam int numRandom    = 64;
    localparam int timeoutLimit = 16 + 8 * (numVectors + numRandom) + 20;

    int          cycleCount = 0;
    logic [31:0] rngState;

    aluCore u_aluCore
    (
        .clk     (clk),
        .reset   (reset),
        .req     (req),
        .ack     (ack),
        .request (request),
        .result  (result)
    );

    always #50 clk = ~clk;   // 100 ns period

    always @(posedge clk)
        cycleCount <= cycleCount + 1;

    initial
    begin
        wait (cycleCount > timeoutLimit);
        $display("Timeout: no end of run after %0d cycles", timeoutLimit);
        $display("Test failed");
        $fatal(1, "stopping on timeout");
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // expected result straight from the opcode rules, wide arithmetic only
    function automatic aluPkg::aluResult modelResult(input aluPkg::aluRequest r);
        aluPkg::aluResult      res;
        logic [`ALU_WIDTH:0]   wideSum;
        logic [`ALU_WIDTH-1:0] diff;
        logic                  addOvf;
        logic                  subOvf;
        wideSum = {1'b0, r.a} + {1'b0, r.b};
        diff    = r.a - r.b;
        addOvf  = (r.a[`ALU_WIDTH-1] == r.b[`ALU_WIDTH-1])
               && (wideSum[`ALU_WIDTH-1] != r.a[`ALU_WIDTH-1]);
        subOvf  = (r.a[`ALU_WIDTH-1] != r.b[`ALU_WIDTH-1])
               && (diff[`ALU_WIDTH-1] != r.a[`ALU_WIDTH-1]);
        res = '0;
        case (r.op)
            aluPkg::OP_ADD:
            begin
                res.value    = wideSum[`ALU_WIDTH-1:0];
                res.carryout = wideSum[`ALU_WIDTH];
                res.overflow = addOvf;
            end
            aluPkg::OP_SUB:
            begin
                res.value    = diff;
                res.carryout = (r.a >= r.b);   // no borrow
                res.overflow = subOvf;
            end
            aluPkg::OP_SLT:
            begin
                res.value    = ($signed(r.a) < $signed(r.b)) ? 1 : 0;
                res.carryout = (r.a >= r.b);
                res.overflow = subOvf;
            end
            aluPkg::OP_AND:  res.value = r.a & r.b;
            aluPkg::OP_OR:   res.value = r.a | r.b;
            aluPkg::OP_XOR:  res.value = r.a ^ r.b;
            aluPkg::OP_NAND: res.value = ~(r.a & r.b);
            default:         res.value = ~(r.a | r.b);
        endcase
        res.zero = (res.value == '0);
        return res;
    endfunction

    task automatic checkResult(input string name, input aluPkg::aluResult expected,
                               input aluPkg::aluResult actual);
        if (actual !== expected)
        begin
            $display("Mismatch at %0t ns: %s expected %h actual %h",
                     $time, name, expected, actual);
            $display("Test failed");
            $fatal(1, "stopping on first error");
        end
    endtask

    task automatic checkAck(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("Mismatch at %0t ns: %s expected %b actual %b",
                     $time, name, expected, actual);
            $display("Test failed");
            $fatal(1, "stopping on first error");
        end
    endtask

    // one full four-phase handshake, entered and left 5 ns after an edge
    task automatic runTransaction(input aluPkg::aluRequest r, input aluPkg::aluResult expected,
                                  input int holdCycles);
        request = r;
        req     = 1'b1;
        for (int k = 0; k < 3; k++)
        begin
            @(posedge clk);
            #5;
            checkAck("ack", (k == 2), ack);   // high two edges after the sampling edge
        end
        checkResult("result", expected, result);
        repeat (holdCycles)
        begin
            @(posedge clk);
            #5;
            checkAck("ack", 1'b1, ack);
            checkResult("result", expected, result);
        end
        req = 1'b0;
        @(posedge clk);
        #5;
        checkAck("ack", 1'b0, ack);
        @(posedge clk);   // release cycle
        #5;
    endtask

    initial
    begin
        aluPkg::aluRequest r;
        clk        = 1'b0;
        reset      = 1'b1;
        req        = 1'b0;
        request    = '0;
        rngState   = 32'h38ef;

        repeat (16) @(posedge clk);
        #5 reset = 1'b0;
        checkAck("ack", 1'b0, ack);
        checkResult("result", '0, result);

        for (int i = 0; i < numVectors; i++)
        begin
            rngState = xorshift(rngState);
            runTransaction(vectors[i].request, vectors[i].expected, rngState % 4);
        end

        for (int i = 0; i < numRandom; i++)
        begin
            rngState = xorshift(rngState);
            r.op     = aluPkg::aluOp'(rngState[2:0]);
            rngState = xorshift(rngState);
            r.a      = rngState;
            rngState = xorshift(rngState);
            r.b      = (rngState[5:4] == 2'b00) ? r.a : rngState;   // equal operands now and then
            rngState = xorshift(rngState);
            runTransaction(r, modelResult(r), rngState % 4);
        end

        $display("Test passed");
        $finish;
    end

endmodule
